//--- logic/cfu_defines.svh
// --------------------------------------------------
// Width macros for the jump execute unit
// Include wherever a data, sequence or register
// index width is needed
// --------------------------------------------------

`ifndef CFU_DEFINES_SVH
`define CFU_DEFINES_SVH

// --------------------------------------------------
// Datapath
// --------------------------------------------------

// Data word, also pc, link and target width
`define CFU_XLEN 32

// --------------------------------------------------
// Tags and register indices
// --------------------------------------------------

// Sequence number carried from dispatch to commit
`define CFU_SEQ_NUM_BITS 5

// Architectural register index, x0..x31
`define CFU_REG_ADDR_BITS 5

`endif

//--- logic/cfu_pkg.sv
// --------------------------------------------------
// Shared types of the jump execute unit
// Micro-op encoding and the payloads of both stages
// --------------------------------------------------

`include "cfu_defines.svh"

package cfu_pkg;

  // --------------------------------------------------
  // Micro-op
  // --------------------------------------------------

  // Only the two unconditional jumps reach this unit
  typedef enum logic {
    UOP_JAL  = 1'b0,
    UOP_JALR = 1'b1
  } cfu_uop_t;

  // --------------------------------------------------
  // Stage payloads
  // --------------------------------------------------

  // Target stage to writeback stage
  typedef struct packed {
    logic [`CFU_XLEN-1:0]          pc;
    logic [`CFU_SEQ_NUM_BITS-1:0]  seq_num;
    logic [`CFU_REG_ADDR_BITS-1:0] waddr;
    // Return address, pc + 4
    logic [`CFU_XLEN-1:0]          link;
    logic [`CFU_XLEN-1:0]          target;
  } cfu_x_msg_t;

  // Writeback stage to commit side
  typedef struct packed {
    logic [`CFU_XLEN-1:0]          pc;
    logic [`CFU_SEQ_NUM_BITS-1:0]  seq_num;
    logic [`CFU_REG_ADDR_BITS-1:0] waddr;
    // Zero whenever wen is low
    logic [`CFU_XLEN-1:0]          wdata;
    logic                          wen;
    logic [`CFU_XLEN-1:0]          target;
  } cfu_w_msg_t;

endpackage

//--- logic/cfu_pipe_reg.sv
// --------------------------------------------------
// One-entry valid/ready pipeline register
// Payload type set per instance, full throughput
// --------------------------------------------------

`timescale 1ns/1ps

module cfu_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,

  // Upstream side
  input  logic     in_val,
  output logic     in_rdy,
  input  payload_t in_msg,

  // Downstream side
  output logic     out_val,
  input  logic     out_rdy,
  output payload_t out_msg
);

  // Entry state
  logic     full;
  payload_t msg_q;
  logic     in_fire;

  // Free when empty or when the held item leaves this cycle
  assign in_rdy  = !full || out_rdy;
  assign in_fire = in_val && in_rdy;

  // Full flag, control state only
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (in_fire) begin
      full <= 1'b1;
    end else if (out_rdy) begin
      // Item left with nothing behind it
      full <= 1'b0;
    end
  end

  // Payload storage, loaded on accept
  always_ff @(posedge clk) begin
    if (in_fire) begin
      msg_q <= in_msg;
    end
  end

  assign out_val = full;
  assign out_msg = msg_q;

endmodule

//--- logic/cfu_target_stage.sv
// --------------------------------------------------
// First stage of the jump unit
// Computes jump target and link, then registers
// the result toward the writeback stage
// --------------------------------------------------

`timescale 1ns/1ps

`include "cfu_defines.svh"

module cfu_target_stage (
  input  logic                          clk,
  input  logic                          rst_n,

  // Dispatch side
  input  logic                          d_val,
  output logic                          d_rdy,
  input  logic [`CFU_XLEN-1:0]          d_pc,
  input  logic [`CFU_SEQ_NUM_BITS-1:0]  d_seq_num,
  input  logic [`CFU_XLEN-1:0]          d_op1,
  input  logic [`CFU_XLEN-1:0]          d_imm,
  input  logic [`CFU_REG_ADDR_BITS-1:0] d_waddr,
  input  cfu_pkg::cfu_uop_t             d_uop,

  // Toward writeback stage
  output logic                          x_val,
  input  logic                          x_rdy,
  output cfu_pkg::cfu_x_msg_t           x_msg
);

  // --------------------------------------------------
  // Target and link
  // --------------------------------------------------

  logic                 is_jalr;
  logic [`CFU_XLEN-1:0] base;
  logic [`CFU_XLEN-1:0] sum;
  logic [`CFU_XLEN-1:0] target;
  logic [`CFU_XLEN-1:0] link;

  assign is_jalr = (d_uop == cfu_pkg::UOP_JALR);

  // JAL is pc relative, JALR is register relative
  assign base = is_jalr ? d_op1 : d_pc;
  assign sum  = base + d_imm;

  // JALR drops bit 0 of the sum
  assign target = is_jalr ? {sum[`CFU_XLEN-1:1], 1'b0} : sum;

  // Return address of the next sequential instruction
  assign link = d_pc + `CFU_XLEN'd4;

  // --------------------------------------------------
  // Stage register
  // --------------------------------------------------

  cfu_pkg::cfu_x_msg_t x_next;

  always_comb begin
    x_next.pc      = d_pc;
    x_next.seq_num = d_seq_num;
    x_next.waddr   = d_waddr;
    x_next.link    = link;
    x_next.target  = target;
  end

  cfu_pipe_reg #(
    .payload_t (cfu_pkg::cfu_x_msg_t)
  ) x_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_val  (d_val),
    .in_rdy  (d_rdy),
    .in_msg  (x_next),
    .out_val (x_val),
    .out_rdy (x_rdy),
    .out_msg (x_msg)
  );

endmodule

//--- logic/cfu_writeback_stage.sv
// --------------------------------------------------
// Second stage of the jump unit
// Builds the writeback message and its enable,
// registered toward the commit side
// --------------------------------------------------

`timescale 1ns/1ps

`include "cfu_defines.svh"

module cfu_writeback_stage (
  input  logic                clk,
  input  logic                rst_n,

  // From target stage
  input  logic                x_val,
  output logic                x_rdy,
  input  cfu_pkg::cfu_x_msg_t x_msg,

  // Commit side
  output logic                w_val,
  input  logic                w_rdy,
  output cfu_pkg::cfu_w_msg_t w_msg
);

  // --------------------------------------------------
  // Writeback enable and data
  // --------------------------------------------------

  logic                 wen;
  logic [`CFU_XLEN-1:0] wdata;

  // x0 is hardwired zero, never written
  assign wen = (x_msg.waddr != `CFU_REG_ADDR_BITS'd0);

  // Link goes to rd, zero data when no write
  assign wdata = wen ? x_msg.link : '0;

  // --------------------------------------------------
  // Stage register
  // --------------------------------------------------

  cfu_pkg::cfu_w_msg_t w_next;

  always_comb begin
    w_next.pc      = x_msg.pc;
    w_next.seq_num = x_msg.seq_num;
    w_next.waddr   = x_msg.waddr;
    w_next.wdata   = wdata;
    w_next.wen     = wen;
    // Target passes straight through
    w_next.target  = x_msg.target;
  end

  cfu_pipe_reg #(
    .payload_t (cfu_pkg::cfu_w_msg_t)
  ) w_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_val  (x_val),
    .in_rdy  (x_rdy),
    .in_msg  (w_next),
    .out_val (w_val),
    .out_rdy (w_rdy),
    .out_msg (w_msg)
  );

endmodule

//--- logic/cfu_top.sv
// --------------------------------------------------
// Jump execute unit, top level
// Takes JAL/JALR from dispatch, returns writeback
// two cycles later through a two-stage pipeline
// --------------------------------------------------

`timescale 1ns/1ps

`include "cfu_defines.svh"

module cfu_top (
  input  logic                          clk,
  input  logic                          rst_n,

  // --------------------------------------------------
  // Dispatch side
  // --------------------------------------------------
  input  logic                          d_val,
  output logic                          d_rdy,
  input  logic [`CFU_XLEN-1:0]          d_pc,
  input  logic [`CFU_SEQ_NUM_BITS-1:0]  d_seq_num,
  input  logic [`CFU_XLEN-1:0]          d_op1,
  input  logic [`CFU_XLEN-1:0]          d_imm,
  input  logic [`CFU_REG_ADDR_BITS-1:0] d_waddr,
  input  cfu_pkg::cfu_uop_t             d_uop,

  // --------------------------------------------------
  // Writeback side
  // --------------------------------------------------
  output logic                          w_val,
  input  logic                          w_rdy,
  output logic [`CFU_XLEN-1:0]          w_pc,
  output logic [`CFU_SEQ_NUM_BITS-1:0]  w_seq_num,
  output logic [`CFU_REG_ADDR_BITS-1:0] w_waddr,
  output logic [`CFU_XLEN-1:0]          w_wdata,
  output logic                          w_wen,
  output logic [`CFU_XLEN-1:0]          w_target
);

  // Link between the stages
  logic                x_val;
  logic                x_rdy;
  cfu_pkg::cfu_x_msg_t x_msg;

  // Registered writeback payload
  cfu_pkg::cfu_w_msg_t w_msg;

  // Stage 1, target and link
  cfu_target_stage target_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .d_val     (d_val),
    .d_rdy     (d_rdy),
    .d_pc      (d_pc),
    .d_seq_num (d_seq_num),
    .d_op1     (d_op1),
    .d_imm     (d_imm),
    .d_waddr   (d_waddr),
    .d_uop     (d_uop),
    .x_val     (x_val),
    .x_rdy     (x_rdy),
    .x_msg     (x_msg)
  );

  // Stage 2, writeback message
  cfu_writeback_stage writeback_stage (
    .clk   (clk),
    .rst_n (rst_n),
    .x_val (x_val),
    .x_rdy (x_rdy),
    .x_msg (x_msg),
    .w_val (w_val),
    .w_rdy (w_rdy),
    .w_msg (w_msg)
  );

  // Unpack onto the commit-side ports
  assign w_pc      = w_msg.pc;
  assign w_seq_num = w_msg.seq_num;
  assign w_waddr   = w_msg.waddr;
  assign w_wdata   = w_msg.wdata;
  assign w_wen     = w_msg.wen;
  assign w_target  = w_msg.target;

endmodule

//--- verif/cfu_tb_ref.svh
// --------------------------------------------------
// Reference model and random source of the jump
// unit testbench that is included inside the module
// --------------------------------------------------

`ifndef CFU_TB_REF_SVH
`define CFU_TB_REF_SVH

`include "cfu_defines.svh"

// 32-bit xorshift with shifts 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] state);
  logic [31:0] x;
  x = state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// Expected writeback for one dispatched jump
function automatic cfu_pkg::cfu_w_msg_t expected_wb(
  input logic [`CFU_XLEN-1:0]          pc,
  input logic [`CFU_SEQ_NUM_BITS-1:0]  seq_num,
  input logic [`CFU_XLEN-1:0]          op1,
  input logic [`CFU_XLEN-1:0]          imm,
  input logic [`CFU_REG_ADDR_BITS-1:0] waddr,
  input cfu_pkg::cfu_uop_t             uop
);
  cfu_pkg::cfu_w_msg_t m;
  logic [`CFU_XLEN-1:0] sum;
  m.pc      = pc;
  m.seq_num = seq_num;
  m.waddr   = waddr;
  // JALR adds imm to the register and clears the low bit
  sum = op1 + imm;
  if (uop == cfu_pkg::UOP_JALR) begin
    m.target = sum & ~`CFU_XLEN'd1;
  end else begin
    m.target = pc + imm;
  end
  // rd gets pc + 4 unless it is x0
  m.wen   = (waddr != '0);
  m.wdata = m.wen ? pc + `CFU_XLEN'd4 : '0;
  return m;
endfunction

`endif

//--- verif/cfu_tb.sv
// --------------------------------------------------
// Testbench of the jump execute unit
// Directed and random JAL/JALR items with every
// writeback checked against the reference model
// --------------------------------------------------

`timescale 1ns/1ps

`include "cfu_defines.svh"

module cfu_tb;

  localparam int RESET_CYCLES   = 16;
  localparam int RANDOM_ITEMS   = 200;
  // 14 directed items ahead of the random stream
  localparam int TOTAL_ITEMS    = 14 + RANDOM_ITEMS;
  localparam int TIMEOUT_CYCLES = TOTAL_ITEMS * 20 + RESET_CYCLES;

  logic                          clk;
  logic                          rst_n;
  logic                          d_val;
  logic                          d_rdy;
  logic [`CFU_XLEN-1:0]          d_pc;
  logic [`CFU_SEQ_NUM_BITS-1:0]  d_seq_num;
  logic [`CFU_XLEN-1:0]          d_op1;
  logic [`CFU_XLEN-1:0]          d_imm;
  logic [`CFU_REG_ADDR_BITS-1:0] d_waddr;
  cfu_pkg::cfu_uop_t             d_uop;
  logic                          w_val;
  logic                          w_rdy;
  logic [`CFU_XLEN-1:0]          w_pc;
  logic [`CFU_SEQ_NUM_BITS-1:0]  w_seq_num;
  logic [`CFU_REG_ADDR_BITS-1:0] w_waddr;
  logic [`CFU_XLEN-1:0]          w_wdata;
  logic                          w_wen;
  logic [`CFU_XLEN-1:0]          w_target;

  // Expected writebacks in dispatch order
  cfu_pkg::cfu_w_msg_t exp_q[$];

  int sent_cnt   = 0;
  int recv_cnt   = 0;
  int check_errs = 0;
  int flow_errs  = 0;
  int tests_run  = 0;
  int test_base  = 0;

  logic [31:0]                  stim_rng;
  logic [31:0]                  bp_rng;
  logic [`CFU_SEQ_NUM_BITS-1:0] seq_ctr;
  logic                         stim_done;

  `include "cfu_tb_ref.svh"

  cfu_top dut0 (.*);

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Watchdog of 20 cycles per item plus reset
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  function automatic logic [31:0] rand32();
    stim_rng = xorshift32(stim_rng);
    return stim_rng;
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] want,
                                 input logic [31:0] got);
    $display("FAILED %s expected %h got %h", sig, want, got);
    check_errs++;
  endtask

  task automatic flow_fail(input string msg);
    $display("%s", msg);
    flow_errs++;
  endtask

  // Holds one item on dispatch until accepted
  task automatic drive_item(input logic [`CFU_XLEN-1:0] pc, input logic [`CFU_XLEN-1:0] op1,
                            input logic [`CFU_XLEN-1:0] imm,
                            input logic [`CFU_REG_ADDR_BITS-1:0] waddr,
                            input cfu_pkg::cfu_uop_t uop);
    d_val     = 1'b1;
    d_pc      = pc;
    d_seq_num = seq_ctr;
    d_op1     = op1;
    d_imm     = imm;
    d_waddr   = waddr;
    d_uop     = uop;
    @(posedge clk);
    while (!d_rdy) @(posedge clk);
    #1;
    d_val   = 1'b0;
    seq_ctr = seq_ctr + `CFU_SEQ_NUM_BITS'd1;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic end_test(input string name);
    $display("test %-14s done, %0d errors", name, check_errs + flow_errs - test_base);
    test_base = check_errs + flow_errs;
    tests_run++;
  endtask

  // Counts edges from a lone dispatch into an empty pipe to w_val
  task automatic measure_latency();
    int cycles;
    cycles = 0;
    drive_item(32'h0000_2000, 32'h0, 32'h0000_0100, 5'd10, cfu_pkg::UOP_JAL);
    while (cycles < 8) begin
      @(posedge clk);
      cycles++;
      if (w_val) break;
    end
    #1;
    assert (cycles == 2)
      else flow_fail($sformatf("w_val came %0d cycles after dispatch, expected 2", cycles));
  endtask

  // Random items with d_val gaps and w_rdy back-pressure
  task automatic run_random_stream();
    int                   gap;
    logic [31:0]          r;
    logic [`CFU_XLEN-1:0] pc;
    logic [`CFU_XLEN-1:0] op1;
    logic [`CFU_XLEN-1:0] imm;
    cfu_pkg::cfu_uop_t    uop;
    stim_done = 1'b0;
    fork
      begin
        for (int i = 0; i < RANDOM_ITEMS; i++) begin
          r   = rand32();
          gap = (r[1:0] == 2'd0) ? int'(r[3:2]) : 0;
          repeat (gap) begin
            @(posedge clk);
            #1;
          end
          pc  = rand32() & 32'hFFFF_FFFC;
          op1 = rand32();
          r   = rand32();
          uop = cfu_pkg::cfu_uop_t'(r[26]);
          // 21-bit even imm for JAL and 12-bit imm for JALR
          if (uop == cfu_pkg::UOP_JAL) begin
            imm = {{11{r[20]}}, r[20:1], 1'b0};
          end else begin
            imm = {{20{r[11]}}, r[11:0]};
          end
          drive_item(pc, op1, imm, r[31:27], uop);
        end
        stim_done = 1'b1;
      end
      begin
        while (!stim_done || exp_q.size() != 0) begin
          bp_rng = xorshift32(bp_rng);
          w_rdy  = (bp_rng[1:0] != 2'b00);
          @(posedge clk);
          #1;
        end
        w_rdy = 1'b1;
      end
    join
  endtask

  // --------------------------------------------------
  // Compare process
  // --------------------------------------------------

  always @(posedge clk) begin : compare_proc
    cfu_pkg::cfu_w_msg_t want;
    if (rst_n) begin
      // Stall only with both stages full
      assert (d_rdy || exp_q.size() == 2)
        else report_mismatch("d_rdy", 32'h1, 32'(d_rdy));
      if (w_val && w_rdy) begin
        if (exp_q.size() == 0) begin
          $display("Writeback seen with no item in flight");
          check_errs++;
        end else begin
          want = exp_q.pop_front();
          recv_cnt++;
          assert (w_seq_num === want.seq_num)
            else report_mismatch("w_seq_num", 32'(want.seq_num), 32'(w_seq_num));
          assert (w_pc === want.pc) else report_mismatch("w_pc", want.pc, w_pc);
          assert (w_waddr === want.waddr)
            else report_mismatch("w_waddr", 32'(want.waddr), 32'(w_waddr));
          assert (w_wen === want.wen) else report_mismatch("w_wen", 32'(want.wen), 32'(w_wen));
          assert (w_wdata === want.wdata) else report_mismatch("w_wdata", want.wdata, w_wdata);
          assert (w_target === want.target)
            else report_mismatch("w_target", want.target, w_target);
        end
      end
      if (d_val && d_rdy) begin
        exp_q.push_back(expected_wb(d_pc, d_seq_num, d_op1, d_imm, d_waddr, d_uop));
        sent_cnt++;
      end
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    rst_n     = 1'b0;
    d_val     = 1'b0;
    d_pc      = '0;
    d_seq_num = '0;
    d_op1     = '0;
    d_imm     = '0;
    d_waddr   = '0;
    d_uop     = cfu_pkg::UOP_JAL;
    w_rdy     = 1'b1;
    seq_ctr   = '0;
    stim_done = 1'b0;
    stim_rng  = 32'h2d36_6f23;
    bp_rng    = xorshift32(~32'h2d36_6f23);
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle outputs straight out of reset
    assert (w_val === 1'b0) else flow_fail($sformatf("FAILED w_val expected 0 got %h", w_val));
    assert (d_rdy === 1'b1) else flow_fail($sformatf("FAILED d_rdy expected 1 got %h", d_rdy));
    end_test("reset_state");

    // pc relative so op1 is ignored
    drive_item(32'h0000_1000, 32'hDEAD_BEEF, 32'h0000_0008, 5'd1, cfu_pkg::UOP_JAL);
    drive_item(32'h0000_2000, 32'h0000_0000, 32'hFFFF_FFF0, 5'd2, cfu_pkg::UOP_JAL);
    drive_item(32'h0001_0004, 32'h1234_5678, 32'hFFF0_0000, 5'd31, cfu_pkg::UOP_JAL);
    drive_item(32'h8000_0000, 32'h0000_0000, 32'h000F_FFFE, 5'd3, cfu_pkg::UOP_JAL);
    drive_item(32'hFFFF_FFFC, 32'h0000_0000, 32'h0000_0010, 5'd4, cfu_pkg::UOP_JAL);
    wait_drain();
    end_test("jal_directed");

    // Odd sums lose bit 0
    drive_item(32'h0000_1000, 32'h0000_3000, 32'h0000_0010, 5'd5, cfu_pkg::UOP_JALR);
    drive_item(32'h0000_1004, 32'h0000_3001, 32'h0000_0000, 5'd6, cfu_pkg::UOP_JALR);
    drive_item(32'h0000_1008, 32'h0000_4000, 32'hFFFF_FFFF, 5'd7, cfu_pkg::UOP_JALR);
    drive_item(32'h0000_100C, 32'h0000_1234, 32'h0000_07FF, 5'd8, cfu_pkg::UOP_JALR);
    drive_item(32'h0000_1010, 32'hFFFF_FFFF, 32'h0000_0002, 5'd9, cfu_pkg::UOP_JALR);
    wait_drain();
    end_test("jalr_directed");

    // rd is x0 so no write and zero data
    drive_item(32'h0000_3000, 32'h0000_0000, 32'h0000_0040, 5'd0, cfu_pkg::UOP_JAL);
    drive_item(32'h0000_3004, 32'h0000_5555, 32'h0000_0010, 5'd0, cfu_pkg::UOP_JALR);
    drive_item(32'h0000_3008, 32'h0000_0000, 32'hFFFF_F000, 5'd0, cfu_pkg::UOP_JAL);
    wait_drain();
    end_test("x0_dest");

    measure_latency();
    wait_drain();
    end_test("latency");

    run_random_stream();
    wait_drain();
    // Two edges push any stray item through both stages
    repeat (2) @(posedge clk);
    #1;
    assert (w_val === 1'b0) else flow_fail("Extra writeback pending after the last item");
    end_test("random_stream");

    // Nothing lost or duplicated
    assert (recv_cnt == sent_cnt && sent_cnt == TOTAL_ITEMS)
      else flow_fail($sformatf("Sent %0d items, written back %0d, expected %0d",
                               sent_cnt, recv_cnt, TOTAL_ITEMS));

    $display("Summary: %0d tests, %0d items, %0d errors", tests_run, recv_cnt,
             check_errs + flow_errs);
    if (check_errs + flow_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+logic
+incdir+verif
logic/cfu_pkg.sv
logic/cfu_pipe_reg.sv
logic/cfu_target_stage.sv
logic/cfu_writeback_stage.sv
logic/cfu_top.sv
verif/cfu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the jump unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f src.f --top-module cfu_tb -o cfu_sim \
  > build.log 2>&1 &&
  ./obj_dir/cfu_sim > sim.log 2>&1 ||
  { echo "Build or run error, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "SIMULATION FAILED" sim.log &&
  { echo "Result: fail"; exit 1; } ||
  { echo "Result: pass"; exit 0; }
